// File: design/bist_params.svh
// Size and depth constants for the systolic array BIST.
// Include this wherever a width or a pattern count is needed.

`ifndef BIST_PARAMS_SVH
`define BIST_PARAMS_SVH

// array geometry, rows = columns
`define SYSTOLIC_SIZE 8

// operand widths
`define WEIGHT_WIDTH 8
`define ACTIVATION_WIDTH 8

// weight + activation + log2(size)
`define PSUM_WIDTH 19

`define ADDR_WIDTH 3              // accumulator row address

// test lengths
`define MBIST_PATTERN_DEPTH 8     // march backgrounds
`define SA_PATTERN_DEPTH 12       // stuck-at entries in eNVM
`define PATTERN_INDEX_WIDTH 4

`endif

// File: design/bist_pkg.sv
// Word and state types shared by the BIST controller blocks.
// Modules import it inside their body and use scoped names in ports.

`include "bist_params.svh"

package bist_pkg;

    // operand words fed into the array
    typedef logic [`WEIGHT_WIDTH-1:0] weight_t;
    typedef logic [`ACTIVATION_WIDTH-1:0] act_t;

    // accumulator side
    typedef logic [`PSUM_WIDTH-1:0] psum_t;
    typedef psum_t [`SYSTOLIC_SIZE-1:0] psum_row_t;   // element c is column c
    typedef logic [`ADDR_WIDTH-1:0] row_addr_t;

    typedef logic [`PATTERN_INDEX_WIDTH-1:0] pattern_index_t;
    typedef logic [`SYSTOLIC_SIZE-1:0] col_mask_t;    // one bit per column

    // top level test flow
    typedef enum logic [2:0] {
        idle,
        mbist_run,
        mbist_last_read,   // pipeline drain, last row read back
        sa_run,
        complete,
        fail
    } bist_state_t;

endpackage

// File: design/bist_controller.sv
// Top FSM of the BIST. Launches MBIST or stuck-at LBIST on start,
// waits for the sequencer to finish and holds test_done until start drops.

`timescale 1ns/1ps

module bist_controller (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic bist_mode,      // 0 mbist, 1 lbist
    input  logic mbist_last,
    input  logic sa_last,
    input  logic mismatch,
    output logic mbist_go,
    output logic sa_go,
    output logic mbist_active,
    output logic test_done,
    output logic mbist_fail
);

    import bist_pkg::*;

    bist_state_t state, state_nxt;
    logic        go_seen;        // a test was launched since the last idle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (start) begin
                    state_nxt = bist_mode ? sa_run : mbist_run;
                end
            end
            mbist_run: begin
                if (mismatch) begin
                    state_nxt = fail;          // first bad row ends the run
                end else if (mbist_last) begin
                    state_nxt = mbist_last_read;
                end
            end
            mbist_last_read: state_nxt = mismatch ? fail : complete;
            sa_run: begin
                if (sa_last) state_nxt = complete;
            end
            complete, fail: begin
                if (!start) state_nxt = idle;  // level handshake back to idle
            end
            default: state_nxt = idle;
        endcase
    end

    assign mbist_go     = (state == idle) && start && !bist_mode;
    assign sa_go        = (state == idle) && start && bist_mode;
    assign mbist_active = (state == mbist_run) || (state == mbist_last_read);
    assign test_done    = (state == complete) || (state == fail);
    assign mbist_fail   = (state == fail);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            go_seen <= 1'b0;
        end else if (mbist_go || sa_go) begin
            go_seen <= 1'b1;
        end else if (state == idle) begin
            go_seen <= 1'b0;
        end
    end

    // done must always belong to a test that was actually launched
    a_done_needs_go : assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(test_done) |-> go_seen
    );

endmodule

// File: design/mbist_sequencer.sv
// March sequencer for the accumulator memory. Writes every row with each
// background pattern, one row per cycle, and reads the row back a cycle later.

`timescale 1ns/1ps
`include "bist_params.svh"

module mbist_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mbist_go,
    input  logic                 mbist_active,   // low in fail, freezes the run
    output logic                 acc_wr_en,
    output bist_pkg::row_addr_t  acc_wr_addr,
    output bist_pkg::row_addr_t  acc_rd_addr,
    output bist_pkg::psum_row_t  acc_wr_data,
    output bist_pkg::psum_t      expected_word,
    output logic                 rd_valid,
    output logic                 mbist_last
);

    import bist_pkg::*;

    localparam int PAT_W = $clog2(`MBIST_PATTERN_DEPTH);
    localparam int BYTES = (`PSUM_WIDTH + 7) / 8;

    logic             wr_active;
    logic             rd_pending;
    row_addr_t        row_cnt;
    logic [PAT_W-1:0] pat_cnt;
    psum_t            cur_word;

    // byte pattern repeated over the whole word
    function automatic psum_t background(input logic [PAT_W-1:0] idx);
        logic [7:0]         b;
        logic [BYTES*8-1:0] wide;
        case (idx)
            3'd0:    b = 8'h00;
            3'd1:    b = 8'hff;
            3'd2:    b = 8'h55;   // 01 01
            3'd3:    b = 8'haa;
            3'd4:    b = 8'h33;   // 0011
            3'd5:    b = 8'hcc;
            3'd6:    b = 8'h0f;
            default: b = 8'hf0;
        endcase
        wide = {BYTES{b}};
        return wide[`PSUM_WIDTH-1:0];
    endfunction

    assign cur_word    = background(pat_cnt);
    assign acc_wr_en   = wr_active && mbist_active;
    assign acc_wr_addr = row_cnt;
    assign acc_wr_data = {`SYSTOLIC_SIZE{cur_word}};
    assign mbist_last  = acc_wr_en && (row_cnt == row_addr_t'(`SYSTOLIC_SIZE - 1))
                         && (pat_cnt == PAT_W'(`MBIST_PATTERN_DEPTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_active <= 1'b0;
            row_cnt   <= '0;
            pat_cnt   <= '0;
        end else if (mbist_go) begin
            wr_active <= 1'b1;
            row_cnt   <= '0;
            pat_cnt   <= '0;
        end else if (acc_wr_en) begin
            if (mbist_last) wr_active <= 1'b0;
            if (row_cnt == row_addr_t'(`SYSTOLIC_SIZE - 1)) begin
                row_cnt <= '0;
                pat_cnt <= pat_cnt + 1'b1;    // next background
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end else if (!mbist_active) begin
            wr_active <= 1'b0;
        end
    end

    // read side trails the write by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_pending  <= 1'b0;
            acc_rd_addr <= '0;
        end else begin
            rd_pending  <= acc_wr_en;
            acc_rd_addr <= acc_wr_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_wr_en) expected_word <= cur_word;
    end

    assign rd_valid = rd_pending && mbist_active;

    a_rd_wr_addr_differ : assert property (
        @(posedge clk) disable iff (!rst_n)
        (acc_wr_en && rd_valid) |-> (acc_wr_addr != acc_rd_addr)
    );

endmodule

// File: design/sa_scan_sequencer.sv
// Stuck-at scan sequencer. Each eNVM pattern takes shift cycles for every
// row, then one capture and one compare cycle, over all stuck-at patterns.

`timescale 1ns/1ps
`include "bist_params.svh"

module sa_scan_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sa_go,
    input  bist_pkg::weight_t        envm_weight,
    input  bist_pkg::act_t           envm_activation,
    output bist_pkg::pattern_index_t pattern_index,
    output logic                     scan_en,
    output bist_pkg::weight_t        weight_test,
    output bist_pkg::act_t           act_test,
    output logic                     load_answer,
    output logic                     sa_compare,
    output logic                     sa_last
);

    import bist_pkg::*;

    localparam int PHASES  = `SYSTOLIC_SIZE + 2;   // shift, capture, compare
    localparam int PHASE_W = $clog2(PHASES);

    localparam logic [PHASE_W-1:0] LAST_SHIFT = PHASE_W'(`SYSTOLIC_SIZE - 1);
    localparam logic [PHASE_W-1:0] COMPARE    = PHASE_W'(PHASES - 1);

    logic               running;
    logic [PHASE_W-1:0] phase;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running       <= 1'b0;
            phase         <= '0;
            pattern_index <= '0;
        end else if (sa_go) begin
            running       <= 1'b1;
            phase         <= '0;
            pattern_index <= '0;
        end else if (running) begin
            if (phase == COMPARE) begin
                phase <= '0;
                if (sa_last) begin
                    running       <= 1'b0;
                    pattern_index <= '0;
                end else begin
                    pattern_index <= pattern_index + 1'b1;
                end
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    assign scan_en     = running && (phase <= LAST_SHIFT);
    assign load_answer = running && (phase == LAST_SHIFT);   // answer for this entry
    assign sa_compare  = running && (phase == COMPARE);
    assign sa_last     = sa_compare
                         && (pattern_index == pattern_index_t'(`SA_PATTERN_DEPTH - 1));

    // array sees test data only while shifting
    assign weight_test = scan_en ? envm_weight : '0;
    assign act_test    = scan_en ? envm_activation : '0;

    // compare follows a capture cycle with scan off
    a_compare_after_capture : assert property (
        @(posedge clk) disable iff (!rst_n)
        sa_compare |-> (!scan_en && $past(!scan_en))
    );

endmodule

// File: design/result_checker.sv
// Column comparator for both tests. MBIST reads raise mismatch at once,
// stuck-at compares build a sticky per-column fail mask.

`timescale 1ns/1ps
`include "bist_params.svh"

module result_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sa_go,
    input  bist_pkg::psum_t     expected_word,     // mbist read side
    input  logic                rd_valid,
    input  bist_pkg::psum_t     envm_answer,
    input  logic                load_answer,
    input  logic                sa_compare,
    input  bist_pkg::psum_row_t partial_sum_flat,
    output bist_pkg::col_mask_t compared_results,
    output logic                mismatch,
    output bist_pkg::col_mask_t sa_fail_cols
);

    import bist_pkg::*;

    psum_t     sa_expected;
    psum_t     expected;
    col_mask_t col_diff;

    // held from the last shift cycle until the compare
    always_ff @(posedge clk) begin
        if (load_answer) sa_expected <= envm_answer;
    end

    assign expected = rd_valid ? expected_word : sa_expected;

    always_comb begin
        for (int c = 0; c < `SYSTOLIC_SIZE; c++) begin
            col_diff[c] = (partial_sum_flat[c] != expected);
        end
    end

    assign compared_results = (rd_valid || sa_compare) ? col_diff : '0;
    assign mismatch         = rd_valid && (|col_diff);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sa_fail_cols <= '0;
        end else if (sa_go) begin
            sa_fail_cols <= '0;                      // fresh mask per run
        end else if (sa_compare) begin
            sa_fail_cols <= sa_fail_cols | col_diff; // sticky
        end
    end

endmodule

// File: design/hybrid_bist.sv
// Top of the systolic array BIST: controller, march sequencer,
// stuck-at scan sequencer and result checker.
// Memory and eNVM sit outside and answer within the cycle.

`timescale 1ns/1ps

module hybrid_bist (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     bist_mode,
    input  bist_pkg::weight_t        envm_weight,
    input  bist_pkg::act_t           envm_activation,
    input  bist_pkg::psum_t          envm_answer,
    input  bist_pkg::psum_row_t      partial_sum_flat,
    output bist_pkg::pattern_index_t pattern_index,
    output logic                     scan_en,
    output bist_pkg::weight_t        weight_test,
    output bist_pkg::act_t           act_test,
    output logic                     acc_wr_en,
    output bist_pkg::row_addr_t      acc_wr_addr,
    output bist_pkg::row_addr_t      acc_rd_addr,
    output bist_pkg::psum_row_t      acc_wr_data,
    output bist_pkg::col_mask_t      compared_results,
    output bist_pkg::col_mask_t      sa_fail_cols,
    output logic                     test_done,
    output logic                     mbist_fail
);

    import bist_pkg::*;

    logic  mbist_go;
    logic  sa_go;
    logic  mbist_active;
    logic  mbist_last;
    logic  sa_last;
    logic  mismatch;
    logic  rd_valid;
    logic  load_answer;
    logic  sa_compare;
    psum_t expected_word;

    bist_controller u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .bist_mode    (bist_mode),
        .mbist_last   (mbist_last),
        .sa_last      (sa_last),
        .mismatch     (mismatch),
        .mbist_go     (mbist_go),
        .sa_go        (sa_go),
        .mbist_active (mbist_active),
        .test_done    (test_done),
        .mbist_fail   (mbist_fail)
    );

    mbist_sequencer u_mbist (
        .clk           (clk),
        .rst_n         (rst_n),
        .mbist_go      (mbist_go),
        .mbist_active  (mbist_active),
        .acc_wr_en     (acc_wr_en),
        .acc_wr_addr   (acc_wr_addr),
        .acc_rd_addr   (acc_rd_addr),
        .acc_wr_data   (acc_wr_data),
        .expected_word (expected_word),
        .rd_valid      (rd_valid),
        .mbist_last    (mbist_last)
    );

    sa_scan_sequencer u_sa (
        .clk             (clk),
        .rst_n           (rst_n),
        .sa_go           (sa_go),
        .envm_weight     (envm_weight),
        .envm_activation (envm_activation),
        .pattern_index   (pattern_index),
        .scan_en         (scan_en),
        .weight_test     (weight_test),
        .act_test        (act_test),
        .load_answer     (load_answer),
        .sa_compare      (sa_compare),
        .sa_last         (sa_last)
    );

    result_checker u_chk (
        .clk              (clk),
        .rst_n            (rst_n),
        .sa_go            (sa_go),
        .expected_word    (expected_word),
        .rd_valid         (rd_valid),
        .envm_answer      (envm_answer),
        .load_answer      (load_answer),
        .sa_compare       (sa_compare),
        .partial_sum_flat (partial_sum_flat),
        .compared_results (compared_results),
        .mismatch         (mismatch),
        .sa_fail_cols     (sa_fail_cols)
    );

endmodule

// File: bench/tb_clock.sv
// Clock and reset source for the BIST testbench.
// 4 ns clock, reset held low for the first three cycles.

`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS  = 4.0,
    parameter int  RST_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;    // released away from the active edge
    end

endmodule

// File: bench/tb_hybrid_bist.sv
// Testbench for hybrid_bist. Models the accumulator memory, the eNVM and
// the array, runs clean and faulty MBIST and stuck-at runs from a fixed seed.

`timescale 1ns/1ps
`include "bist_params.svh"

module tb_hybrid_bist;

    import bist_pkg::*;

    localparam int MBIST_LEN = 66;     // go to complete
    localparam int SA_LEN    = 120;
    localparam int RUNS      = 3;      // runs of each kind
    localparam int TIMEOUT_CYCLES = 4 * (RUNS * MBIST_LEN + RUNS * SA_LEN);

    logic clk, rst_n, start, bist_mode;
    weight_t envm_weight, weight_test;
    act_t envm_activation, act_test;
    psum_t envm_answer;
    psum_row_t partial_sum_flat, acc_wr_data;
    pattern_index_t pattern_index;
    logic scan_en, acc_wr_en, test_done, mbist_fail;
    row_addr_t acc_wr_addr, acc_rd_addr;
    col_mask_t compared_results, sa_fail_cols;

    integer seed;
    int errors, checks, cycles, wr_count, scan_cnt, idx_exp;
    psum_row_t mem [0:`SYSTOLIC_SIZE-1];
    weight_t envm_w [0:`SA_PATTERN_DEPTH-1];
    act_t envm_a [0:`SA_PATTERN_DEPTH-1];
    psum_t envm_ans [0:`SA_PATTERN_DEPTH-1];
    logic stuck_en, stuck_val;
    row_addr_t stuck_row;
    int stuck_col, stuck_bit;
    col_mask_t fault_mask;
    col_mask_t cmp_exp;      // columns expected to differ on a compare
    int cmp_count;
    logic rd_due;            // a write happened last cycle
    row_addr_t rd_row_exp;

    tb_clock u_clk (.clk(clk), .rst_n(rst_n));

    hybrid_bist uut (
        .clk(clk), .rst_n(rst_n), .start(start), .bist_mode(bist_mode),
        .envm_weight(envm_weight), .envm_activation(envm_activation),
        .envm_answer(envm_answer), .partial_sum_flat(partial_sum_flat),
        .pattern_index(pattern_index), .scan_en(scan_en),
        .weight_test(weight_test), .act_test(act_test), .acc_wr_en(acc_wr_en),
        .acc_wr_addr(acc_wr_addr), .acc_rd_addr(acc_rd_addr),
        .acc_wr_data(acc_wr_data), .compared_results(compared_results),
        .sa_fail_cols(sa_fail_cols), .test_done(test_done), .mbist_fail(mbist_fail)
    );

    // eNVM answers within the cycle
    assign envm_weight     = envm_w[pattern_index];
    assign envm_activation = envm_a[pattern_index];
    assign envm_answer     = envm_ans[pattern_index];

    // accumulator memory, filled from row and column during reset
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `SYSTOLIC_SIZE; r++)
                for (int c = 0; c < `SYSTOLIC_SIZE; c++)
                    mem[r][c] <= psum_t'((r * `SYSTOLIC_SIZE + c) * 32'h2f1 + r);
        end else if (acc_wr_en) begin
            mem[acc_wr_addr] <= acc_wr_data;
        end
    end

    // memory read in MBIST, array response in LBIST
    always_comb begin
        for (int c = 0; c < `SYSTOLIC_SIZE; c++) begin
            if (bist_mode) begin
                partial_sum_flat[c] = envm_ans[pattern_index] ^ psum_t'(fault_mask[c]);
            end else begin
                partial_sum_flat[c] = mem[acc_rd_addr][c];
                if (stuck_en && acc_rd_addr == stuck_row && c == stuck_col)
                    partial_sum_flat[c][stuck_bit] = stuck_val;
            end
        end
    end

    // background p, bit b; rightmost character of the pattern is bit 0
    function automatic logic pattern_bit(input int p, input int b);
        int period;
        if (p < 2) return logic'(p);
        period = 2 << ((p - 2) / 2);
        return ((b % period) < (period / 2)) ^ logic'(p % 2);
    endfunction

    function automatic psum_row_t pattern_row(input int p);
        psum_row_t row;
        for (int c = 0; c < `SYSTOLIC_SIZE; c++)
            for (int b = 0; b < `PSUM_WIDTH; b++)
                row[c][b] = pattern_bit(p, b);
        return row;
    endfunction

    // position in write order of the first write the stuck bit corrupts
    function automatic int first_fail_write(input int row, input int b, input logic val);
        for (int p = 0; p < `MBIST_PATTERN_DEPTH; p++)
            if (pattern_bit(p, b) != val) return p * `SYSTOLIC_SIZE + row;
        return `MBIST_PATTERN_DEPTH * `SYSTOLIC_SIZE;
    endfunction

    task automatic check_mask(input string name, input col_mask_t got, input col_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_row(input string name, input psum_row_t got, input psum_row_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input row_addr_t got, input row_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_weight(input string name, input weight_t got, input weight_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_act(input string name, input act_t got, input act_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_index(input string name, input pattern_index_t got,
                               input pattern_index_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR: saw %0d %s, expected %0d", got, what, exp);
        end
    endtask

    // write order, read address and scan data, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && rd_due)
            check_addr("acc_rd_addr", acc_rd_addr, rd_row_exp);
        rd_due = 1'b0;
        if (rst_n && acc_wr_en) begin
            rd_row_exp = row_addr_t'(wr_count % `SYSTOLIC_SIZE);
            check_addr("acc_wr_addr", acc_wr_addr, rd_row_exp);
            check_row("acc_wr_data", acc_wr_data, pattern_row(wr_count / `SYSTOLIC_SIZE));
            rd_due = 1'b1;
            wr_count++;
        end
        if (rst_n && scan_en) begin
            check_index("pattern_index", pattern_index, pattern_index_t'(idx_exp));
            check_weight("weight_test", weight_test, envm_w[idx_exp]);
            check_act("act_test", act_test, envm_a[idx_exp]);
            scan_cnt++;
            if (scan_cnt == `SYSTOLIC_SIZE) begin
                scan_cnt = 0;
                idx_exp++;
            end
        end else if (rst_n) begin
            check_weight("weight_test", weight_test, '0);    // zero outside shift
            check_act("act_test", act_test, '0);
        end
        if (rst_n && compared_results != '0) begin
            check_mask("compared_results", compared_results, cmp_exp);
            cmp_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout, test_done not seen within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic launch_test(input logic mode);
        bist_mode = mode;
        start     = 1'b1;
        @(negedge clk);
        if (mode) check_mask("sa_fail_cols", sa_fail_cols, '0);   // cleared by sa_go
        while (!test_done) @(negedge clk);
    endtask

    task automatic release_start();
        start = 1'b0;
        @(negedge clk);
        check_bit("test_done", test_done, 1'b0);    // back in idle
    endtask

    task automatic run_mbist(input logic with_fault);
        int fail_idx;
        stuck_en  = with_fault;
        stuck_row = row_addr_t'($random(seed));
        stuck_col = {$random(seed)} % `SYSTOLIC_SIZE;
        stuck_bit = {$random(seed)} % `PSUM_WIDTH;
        stuck_val = logic'($random(seed));
        fail_idx  = first_fail_write(int'(stuck_row), stuck_bit, stuck_val);
        wr_count  = 0;
        cmp_exp   = with_fault ? col_mask_t'(1) << stuck_col : '0;
        cmp_count = 0;
        launch_test(1'b0);
        check_bit("mbist_fail", mbist_fail, with_fault);
        // one more write is already issued while the bad row is read
        check_count("MBIST writes", wr_count,
                    with_fault ? fail_idx + 2 : `MBIST_PATTERN_DEPTH * `SYSTOLIC_SIZE);
        check_count("MBIST miscompares", cmp_count, with_fault ? 1 : 0);
        release_start();
    endtask

    task automatic run_sa(input logic with_fault);
        fault_mask = '0;
        if (with_fault) begin
            do fault_mask = col_mask_t'($random(seed)); while (fault_mask == '0);
        end
        idx_exp   = 0;
        scan_cnt  = 0;
        cmp_exp   = fault_mask;
        cmp_count = 0;
        launch_test(1'b1);
        check_mask("sa_fail_cols", sa_fail_cols, fault_mask);
        check_bit("mbist_fail", mbist_fail, 1'b0);
        check_count("stuck-at patterns", idx_exp, `SA_PATTERN_DEPTH);
        check_count("stuck-at miscompares", cmp_count,
                    with_fault ? `SA_PATTERN_DEPTH : 0);
        release_start();
    endtask

    initial begin
        seed = 32'he3cdab14;
        start = 1'b0;
        bist_mode = 1'b0;
        stuck_en = 1'b0;
        stuck_val = 1'b0;
        stuck_row = '0;
        stuck_col = 0;
        stuck_bit = 0;
        fault_mask = '0;
        cmp_exp = '0;
        cmp_count = 0;
        rd_due = 1'b0;
        rd_row_exp = '0;
        errors = 0;
        checks = 0;
        cycles = 0;
        wr_count = 0;
        scan_cnt = 0;
        idx_exp = 0;
        for (int i = 0; i < `SA_PATTERN_DEPTH; i++) begin
            envm_w[i]   = weight_t'($random(seed));
            envm_a[i]   = act_t'($random(seed));
            envm_ans[i] = psum_t'($random(seed));
        end
        wait (rst_n);
        @(negedge clk);
        check_bit("acc_wr_en", acc_wr_en, 1'b0);
        check_bit("scan_en", scan_en, 1'b0);
        check_bit("test_done", test_done, 1'b0);
        check_bit("mbist_fail", mbist_fail, 1'b0);
        check_mask("compared_results", compared_results, '0);
        check_mask("sa_fail_cols", sa_fail_cols, '0);

        // alternate kinds so each run follows one of the other kind
        run_mbist(1'b0);
        run_sa(1'b1);
        run_mbist(1'b1);
        run_sa(1'b0);
        run_mbist(1'b1);
        run_sa(1'b1);

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+design
design/bist_pkg.sv
design/bist_controller.sv
design/mbist_sequencer.sv
design/sa_scan_sequencer.sv
design/result_checker.sv
design/hybrid_bist.sv
bench/tb_clock.sv
bench/tb_hybrid_bist.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_hybrid_bist
FILELIST  ?= src.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
